//--- axi_burst_writer.sv
`timescale 1ns/1ns
`include "dmaw_defines.svh"

module axi_burst_writer
(
    input  logic                 clk,
    input  logic                 reset,
    burst_ctrl_if.writer         ctrl,

    // line stream from the FIFO.
    input  logic                 in_valid,
    output logic                 in_ready,
    input  dmaw_pkg::line_data_t in_data,

    // AXI4 write master.
    output logic                 m_axi_awvalid,
    input  logic                 m_axi_awready,
    output dmaw_pkg::byte_addr_t m_axi_awaddr,
    output dmaw_pkg::burst_len_t m_axi_awlen,
    output logic                 m_axi_wvalid,
    input  logic                 m_axi_wready,
    output dmaw_pkg::line_data_t m_axi_wdata,
    output logic                 m_axi_wlast,
    input  logic                 m_axi_bvalid,
    output logic                 m_axi_bready,
    input  logic [1:0]           m_axi_bresp
);
    import dmaw_pkg::*;

    localparam int PAGE_LINES = 4096 >> `DMAW_BYTE_IDX_BITS;

    // one burst at a time, each walks address, data, response.
    typedef enum logic [1:0]
    {
        PHASE_IDLE,
        PHASE_ADDR,
        PHASE_DATA,
        PHASE_RESP
    } phase_t;

    phase_t      phase;
    byte_addr_t  cur_addr;    // start of the next burst.
    line_count_t remaining;   // lines not yet issued on AW.
    line_count_t page_left;   // lines up to the next 4 KB boundary.
    line_count_t burst_beats; // size of the burst about to be issued.
    line_count_t beats_left;  // beats still owed in the current burst.
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic        done_q;
    logic        error_q;

    assign aw_fire = m_axi_awvalid && m_axi_awready;
    assign w_fire = m_axi_wvalid && m_axi_wready;
    assign b_fire = m_axi_bvalid && m_axi_bready;

    assign page_left = line_count_t'(PAGE_LINES) - line_count_t'(cur_addr[11:`DMAW_BYTE_IDX_BITS]);

    // smallest of the max burst, the lines left and the room in the page.
    always_comb
    begin
        burst_beats = line_count_t'(`DMAW_MAX_BURST);
        if (remaining < burst_beats)
        begin
            burst_beats = remaining;
        end
        if (page_left < burst_beats)
        begin
            burst_beats = page_left;
        end
    end

    // address payload comes from registers, so it holds while AWVALID waits.
    assign m_axi_awvalid = (phase == PHASE_ADDR);
    assign m_axi_awaddr = cur_addr;
    assign m_axi_awlen = burst_len_t'(burst_beats - 1'b1);

    // data passes straight through from the FIFO head.
    assign m_axi_wvalid = (phase == PHASE_DATA) && in_valid;
    assign in_ready = (phase == PHASE_DATA) && m_axi_wready;
    assign m_axi_wdata = in_data;
    assign m_axi_wlast = (beats_left == line_count_t'(1));

    assign m_axi_bready = (phase == PHASE_RESP);

    assign ctrl.done = done_q;
    assign ctrl.resp_error = error_q;
    assign ctrl.ack = b_fire; // the engine registers it.

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= PHASE_IDLE;
            remaining <= '0;
            beats_left <= '0;
            done_q <= 1'b0;
            error_q <= 1'b0;
        end
        else if (ctrl.start)
        begin
            // a start always wins, even in the middle of a burst.
            phase <= (ctrl.length == '0) ? PHASE_IDLE : PHASE_ADDR;
            remaining <= ctrl.length;
            beats_left <= '0;
            done_q <= (ctrl.length == '0); // empty transfer finishes at once.
            error_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (phase)
                PHASE_ADDR:
                begin
                    if (aw_fire)
                    begin
                        remaining <= remaining - burst_beats;
                        beats_left <= burst_beats;
                        phase <= PHASE_DATA;
                    end
                end
                PHASE_DATA:
                begin
                    if (w_fire)
                    begin
                        beats_left <= beats_left - 1'b1;
                        if (m_axi_wlast)
                        begin
                            phase <= PHASE_RESP;
                        end
                    end
                end
                PHASE_RESP:
                begin
                    if (b_fire)
                    begin
                        error_q <= error_q | (m_axi_bresp != 2'b00);
                        done_q <= (remaining == '0);
                        phase <= (remaining == '0) ? PHASE_IDLE : PHASE_ADDR;
                    end
                end
                default: phase <= PHASE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.start)
        begin
            cur_addr <= ctrl.addr;
        end
        else if (aw_fire)
        begin
            cur_addr <= cur_addr + byte_addr_t'(burst_beats << `DMAW_BYTE_IDX_BITS);
        end
    end

endmodule

//--- burst_ctrl_if.sv
`timescale 1ns/1ns

interface burst_ctrl_if;
    import dmaw_pkg::*;

    // request side, driven by the engine.
    logic        start;  // one-cycle pulse.
    byte_addr_t  addr;   // held from start until done.
    line_count_t length; // lines to move, 0 is allowed.

    // completion side, driven by the burst writer.
    logic        done;       // one-cycle pulse after the last response.
    logic        resp_error; // any non-okay response since start.
    logic        ack;        // one-cycle pulse per B handshake.

    modport engine
    (
        output start,
        output addr,
        output length,
        input  done,
        input  resp_error,
        input  ack
    );

    modport writer
    (
        input  start,
        input  addr,
        input  length,
        output done,
        output resp_error,
        output ack
    );

endinterface

//--- dma_write_engine.sv
`timescale 1ns/1ns
`include "dmaw_defines.svh"

module dma_write_engine
(
    input  logic                   clk,
    input  logic                   reset,

    // producer side.
    input  logic                   line_we,
    input  dmaw_pkg::line_data_t   line_wdata,
    output logic                   line_almost_full,

    // control and status.
    input  logic                   start,
    input  dmaw_pkg::line_addr_t   start_line_addr,
    input  dmaw_pkg::line_count_t  start_length,
    output logic                   idle,
    output logic                   active,
    output logic                   done,
    output logic                   ack,
    output logic                   resp_error,

    // AXI4 write master.
    output logic                   m_axi_awvalid,
    input  logic                   m_axi_awready,
    output dmaw_pkg::byte_addr_t   m_axi_awaddr,
    output dmaw_pkg::burst_len_t   m_axi_awlen,
    output logic                   m_axi_wvalid,
    input  logic                   m_axi_wready,
    output dmaw_pkg::line_data_t   m_axi_wdata,
    output logic                   m_axi_wlast,
    input  logic                   m_axi_bvalid,
    output logic                   m_axi_bready,
    input  logic [1:0]             m_axi_bresp
);
    import dmaw_pkg::*;

    write_state_t state;
    logic         fifo_valid;
    logic         fifo_ready;
    line_data_t   fifo_data;

    burst_ctrl_if ctrl_bus ();

    line_fifo send_fifo
    (
        .clk          (clk),
        .reset        (reset),
        .write_enable (line_we),
        .write_data   (line_wdata),
        .out_valid    (fifo_valid),
        .out_ready    (fifo_ready),
        .out_data     (fifo_data),
        .almost_full  (line_almost_full)
    );

    axi_burst_writer burst_writer
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl_bus.writer),
        .in_valid      (fifo_valid),
        .in_ready      (fifo_ready),
        .in_data       (fifo_data),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awlen   (m_axi_awlen),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wlast   (m_axi_wlast),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready),
        .m_axi_bresp   (m_axi_bresp)
    );

    // the done state counts as idle so idle comes back with the done pulse.
    assign idle = (state != STATE_WRITE);
    assign active = (state == STATE_WRITE);
    assign done = (state == STATE_DONE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= STATE_IDLE;
            ctrl_bus.start <= 1'b0;
            ack <= 1'b0;
            resp_error <= 1'b0;
        end
        else
        begin
            ctrl_bus.start <= start; // delayed so address and length are latched.
            ack <= ctrl_bus.ack;
            resp_error <= ctrl_bus.resp_error;
            if (start)
            begin
                state <= STATE_WRITE; // also restarts a running transfer.
            end
            else
            begin
                case (state)
                    STATE_WRITE:
                    begin
                        if (ctrl_bus.done)
                        begin
                            state <= STATE_DONE;
                        end
                    end
                    STATE_DONE: state <= STATE_IDLE;
                    default:    state <= STATE_IDLE;
                endcase
            end
        end
    end

    // transfer parameters, held until the next start.
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            ctrl_bus.addr <= byte_addr_t'(start_line_addr) << `DMAW_BYTE_IDX_BITS;
            ctrl_bus.length <= start_length;
        end
    end

endmodule

//--- dma_write_top.f
+incdir+.
dmaw_pkg.sv
burst_ctrl_if.sv
line_fifo.sv
axi_burst_writer.sv
dma_write_engine.sv
dma_write_top.sv
dma_write_top_assert.sv
tb_dma_write_top.sv

//--- dma_write_top.sv
`timescale 1ns/1ns

module dma_write_top
(
    input  logic                   clk,
    input  logic                   reset,

    // producer side.
    input  logic                   line_we,
    input  dmaw_pkg::line_data_t   line_wdata,
    output logic                   line_almost_full,

    // control and status.
    input  logic                   start,
    input  dmaw_pkg::line_addr_t   start_line_addr,
    input  dmaw_pkg::line_count_t  start_length,
    output logic                   idle,
    output logic                   active,
    output logic                   done,
    output logic                   ack,
    output logic                   resp_error,

    // AXI4 write master, full-width beats only.
    output logic                   m_axi_awvalid,
    input  logic                   m_axi_awready,
    output dmaw_pkg::byte_addr_t   m_axi_awaddr,
    output dmaw_pkg::burst_len_t   m_axi_awlen,
    output logic                   m_axi_wvalid,
    input  logic                   m_axi_wready,
    output dmaw_pkg::line_data_t   m_axi_wdata,
    output logic                   m_axi_wlast,
    input  logic                   m_axi_bvalid,
    output logic                   m_axi_bready,
    input  logic [1:0]             m_axi_bresp
);

    dma_write_engine engine
    (
        .clk              (clk),
        .reset            (reset),
        .line_we          (line_we),
        .line_wdata       (line_wdata),
        .line_almost_full (line_almost_full),
        .start            (start),
        .start_line_addr  (start_line_addr),
        .start_length     (start_length),
        .idle             (idle),
        .active           (active),
        .done             (done),
        .ack              (ack),
        .resp_error       (resp_error),
        .m_axi_awvalid    (m_axi_awvalid),
        .m_axi_awready    (m_axi_awready),
        .m_axi_awaddr     (m_axi_awaddr),
        .m_axi_awlen      (m_axi_awlen),
        .m_axi_wvalid     (m_axi_wvalid),
        .m_axi_wready     (m_axi_wready),
        .m_axi_wdata      (m_axi_wdata),
        .m_axi_wlast      (m_axi_wlast),
        .m_axi_bvalid     (m_axi_bvalid),
        .m_axi_bready     (m_axi_bready),
        .m_axi_bresp      (m_axi_bresp)
    );

endmodule

//--- dma_write_top_assert.sv
`timescale 1ns/1ns

module dma_write_top_assert
(
    input logic                 clk,
    input logic                 reset,
    input logic                 active,
    input logic                 done,
    input logic                 m_axi_awvalid,
    input logic                 m_axi_awready,
    input dmaw_pkg::byte_addr_t m_axi_awaddr,
    input dmaw_pkg::burst_len_t m_axi_awlen,
    input logic                 m_axi_wvalid,
    input logic                 m_axi_wready,
    input dmaw_pkg::line_data_t m_axi_wdata,
    input logic                 m_axi_wlast
);
    int unsigned failures = 0; // failed assertions so far.

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        m_axi_awvalid && !m_axi_awready |=>
            m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
    else
    begin
        failures++;
        $error("AW dropped or changed before AWREADY");
    end

    w_hold: assert property (@(posedge clk) disable iff (reset)
        m_axi_wvalid && !m_axi_wready |=>
            m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast))
    else
    begin
        failures++;
        $error("W dropped or changed before WREADY");
    end

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else
    begin
        failures++;
        $error("done held longer than one cycle");
    end

    // bursts are only issued while the engine reports a transfer in progress.
    aw_in_transfer: assert property (@(posedge clk) disable iff (reset)
        m_axi_awvalid |-> active)
    else
    begin
        failures++;
        $error("AWVALID outside an active transfer");
    end

endmodule

bind dma_write_top dma_write_top_assert checks (.*);

//--- dmaw_defines.svh
`ifndef DMAW_DEFINES_SVH
`define DMAW_DEFINES_SVH

// one cache line is one AXI beat.
`define DMAW_DATA_WIDTH 64
`define DMAW_ADDR_WIDTH 32

// log2 of the bytes per line, turns a line address into a byte address.
`define DMAW_BYTE_IDX_BITS 3

// line FIFO sizing.
`define DMAW_FIFO_LOG2_DEPTH 5
`define DMAW_ALMOST_FULL_MARGIN 4 // free slots left when almost-full rises.

// beats per burst, before the 4 KB page limit is applied.
`define DMAW_MAX_BURST 16

`endif

//--- dmaw_pkg.sv
`include "dmaw_defines.svh"

package dmaw_pkg;

    // one cache line, also one write beat.
    typedef logic [`DMAW_DATA_WIDTH-1:0] line_data_t;

    // memory byte address as seen on AW.
    typedef logic [`DMAW_ADDR_WIDTH-1:0] byte_addr_t;

    // line address from the control side, byte index dropped.
    typedef logic [`DMAW_ADDR_WIDTH-`DMAW_BYTE_IDX_BITS-1:0] line_addr_t;

    typedef logic [31:0] line_count_t; // transfer length in lines.
    typedef logic [7:0]  burst_len_t;  // AXI length field, beats minus one.

    // engine control states.
    typedef enum logic [1:0]
    {
        STATE_IDLE,
        STATE_WRITE,
        STATE_DONE
    } write_state_t;

endpackage

//--- line_fifo.sv
`timescale 1ns/1ns
`include "dmaw_defines.svh"

module line_fifo
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write_enable,
    input  dmaw_pkg::line_data_t write_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output dmaw_pkg::line_data_t out_data,
    output logic                 almost_full
);
    import dmaw_pkg::*;

    localparam int PTR_BITS = `DMAW_FIFO_LOG2_DEPTH;
    localparam int DEPTH = 1 << PTR_BITS;
    localparam logic [PTR_BITS:0] AF_LEVEL = (PTR_BITS + 1)'(DEPTH - `DMAW_ALMOST_FULL_MARGIN);

    line_data_t mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0] count;
    logic full;
    logic do_write;
    logic do_read;

    // count reaches DEPTH exactly when its top bit is set.
    assign full = count[PTR_BITS];

    // a write into a full buffer is ignored rather than overwriting the head.
    assign do_write = write_enable && !full;
    assign do_read = out_valid && out_ready;

    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr]; // head of the queue.
    assign almost_full = (count >= AF_LEVEL);

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH.
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither.
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_write_top -f dma_write_top.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
echo "Pass message not found."
exit 1

//--- tb_dma_write_top.sv
`timescale 1ns/1ns
`include "dmaw_defines.svh"

module tb_dma_write_top;
    import dmaw_pkg::*;

    localparam int WAIT_LIMIT = 5000;
    localparam int LINE_BYTES = `DMAW_DATA_WIDTH / 8;
    localparam int AF_LEVEL = (1 << `DMAW_FIFO_LOG2_DEPTH) - `DMAW_ALMOST_FULL_MARGIN;

    logic        clk = 1'b0;
    logic        reset;
    logic        line_we;
    line_data_t  line_wdata;
    logic        line_almost_full;
    logic        start;
    line_addr_t  start_line_addr;
    line_count_t start_length;
    logic        idle;
    logic        active;
    logic        done;
    logic        ack;
    logic        resp_error;
    logic        m_axi_awvalid;
    logic        m_axi_awready = 1'b0;
    byte_addr_t  m_axi_awaddr;
    burst_len_t  m_axi_awlen;
    logic        m_axi_wvalid;
    logic        m_axi_wready = 1'b0;
    line_data_t  m_axi_wdata;
    logic        m_axi_wlast;
    logic        m_axi_bvalid = 1'b0;
    logic        m_axi_bready;
    logic [1:0]  m_axi_bresp = 2'b00;

    line_data_t  mem_model [byte_addr_t]; // slave memory, keyed by byte address.
    line_data_t  sent_lines [$];          // lines written by the producer, oldest first.
    byte_addr_t  aw_log [$];
    burst_len_t  len_log [$];
    byte_addr_t  exp_addr [$];
    burst_len_t  exp_len [$];
    byte_addr_t  w_addr;
    byte_addr_t  err_addr = '1; // burst start that gets SLVERR.
    logic        burst_bad = 1'b0;
    logic        b_pending = 1'b0;
    logic        heavy_stall = 1'b0;
    logic        af_seen = 1'b0;
    logic        awvalid_seen = 1'b0;
    int          beats_open = 0;
    int          fifo_level = 0;
    int          beat_count = 0;
    int          ack_count = 0;
    int          done_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;

    dma_write_top UUT (.*);

    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        error_count++;
        $display("[ERROR] %s got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Failure: %s at %0t", what, $time);
    endtask

    // AXI slave memory with random ready stalls.
    always @(posedge clk)
    begin
        if (reset)
        begin
            m_axi_awready <= 1'b0;
            m_axi_wready <= 1'b0;
            m_axi_bvalid <= 1'b0;
            beats_open = 0;
            b_pending = 1'b0;
        end
        else
        begin
            m_axi_awready <= ($urandom_range(3) != 0);
            m_axi_wready <= heavy_stall ? ($urandom_range(15) == 0) : ($urandom_range(3) != 0);
            if (m_axi_awvalid && (beats_open != 0 || b_pending))
                report_failure("AWVALID raised before the previous burst finished");
            if (m_axi_awvalid && m_axi_awready)
            begin
                aw_log.push_back(m_axi_awaddr);
                len_log.push_back(m_axi_awlen);
                w_addr = m_axi_awaddr;
                beats_open = int'(m_axi_awlen) + 1;
                burst_bad = (m_axi_awaddr == err_addr);
            end
            else if (m_axi_wvalid && beats_open == 0)
                report_failure("W beat outside an accepted burst");
            else if (m_axi_wvalid && m_axi_wready)
            begin
                if (m_axi_wlast !== (beats_open == 1))
                    report_mismatch("m_axi_wlast", m_axi_wlast, beats_open == 1);
                mem_model[w_addr] = m_axi_wdata;
                w_addr = w_addr + byte_addr_t'(LINE_BYTES);
                beats_open--;
                beat_count++;
                if (beats_open == 0)
                begin
                    m_axi_bvalid <= 1'b1;
                    m_axi_bresp <= burst_bad ? 2'b10 : 2'b00;
                    b_pending = 1'b1;
                end
            end
            if (m_axi_bvalid && m_axi_bready)
            begin
                m_axi_bvalid <= 1'b0;
                b_pending = 1'b0;
            end
        end
    end

    // FIFO level model and pulse counters.
    always @(posedge clk)
    begin
        if (reset)
            fifo_level = 0;
        else
        begin
            if (line_almost_full !== (fifo_level >= AF_LEVEL))
                report_mismatch("line_almost_full", line_almost_full, fifo_level >= AF_LEVEL);
            fifo_level = fifo_level + int'(line_we) - int'(m_axi_wvalid && m_axi_wready);
            if (line_almost_full)
                af_seen = 1'b1;
            if (m_axi_awvalid)
                awvalid_seen = 1'b1;
            if (ack)
                ack_count++;
            if (done)
                done_count++;
        end
    end

    // producer, writes only while almost-full is low.
    task automatic feed_lines(input int count);
        int sent;
        int waited;
        line_data_t value;
        sent = 0;
        waited = 0;
        while (sent < count && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            value = {$urandom, $urandom};
            line_we <= !line_almost_full;
            line_wdata <= value;
            if (!line_almost_full)
            begin
                sent_lines.push_back(value);
                sent++;
                waited = 0;
            end
            else
                waited++;
        end
        @(posedge clk);
        line_we <= 1'b0;
        if (sent < count)
        begin
            timeout_count++;
            $display("Timeout: producer blocked after %0d of %0d lines", sent, count);
        end
    endtask

    // bursts per the page and max-burst rule.
    task automatic plan_bursts(input byte_addr_t addr, input int lines);
        int left;
        int size;
        int page_room;
        exp_addr.delete();
        exp_len.delete();
        left = lines;
        while (left > 0)
        begin
            page_room = (4096 - int'(addr % 4096)) / LINE_BYTES;
            size = (left < `DMAW_MAX_BURST) ? left : `DMAW_MAX_BURST;
            if (page_room < size)
                size = page_room;
            exp_addr.push_back(addr);
            exp_len.push_back(burst_len_t'(size - 1));
            addr = addr + byte_addr_t'(size * LINE_BYTES);
            left = left - size;
        end
    endtask

    task automatic run_transfer(input line_addr_t line_addr, input int lines, input logic exp_error);
        byte_addr_t base;
        int acks_before;
        int dones_before;
        int beats_before;
        int waited;
        int i;
        base = byte_addr_t'(line_addr) * byte_addr_t'(LINE_BYTES);
        plan_bursts(base, lines);
        @(posedge clk);
        aw_log.delete();
        len_log.delete();
        awvalid_seen = 1'b0;
        acks_before = ack_count;
        dones_before = done_count;
        beats_before = beat_count;
        start <= 1'b1;
        start_line_addr <= line_addr;
        start_length <= line_count_t'(lines);
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (idle !== 1'b0)
            report_mismatch("idle", idle, 0);
        if (active !== 1'b1)
            report_mismatch("active", active, 1);
        waited = 0;
        while (done !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (done !== 1'b1)
        begin
            timeout_count++;
            $display("Timeout: no done within %0d cycles of start", WAIT_LIMIT);
        end
        else
        begin
            if (idle !== 1'b1)
                report_mismatch("idle", idle, 1);
            if (resp_error !== exp_error)
                report_mismatch("resp_error", resp_error, exp_error);
            @(posedge clk);
            if (done_count - dones_before != 1)
                report_mismatch("done pulse count", done_count - dones_before, 1);
            if (ack_count - acks_before != exp_addr.size())
                report_mismatch("ack pulse count", ack_count - acks_before, exp_addr.size());
            if (lines == 0 && awvalid_seen)
                report_failure("AWVALID raised for an empty transfer");
            if (aw_log.size() != exp_addr.size())
                report_mismatch("burst count", aw_log.size(), exp_addr.size());
            for (i = 0; i < aw_log.size() && i < exp_addr.size(); i++)
            begin
                if (aw_log[i] !== exp_addr[i])
                    report_mismatch("m_axi_awaddr", aw_log[i], exp_addr[i]);
                if (len_log[i] !== exp_len[i])
                    report_mismatch("m_axi_awlen", len_log[i], exp_len[i]);
            end
            if (beat_count - beats_before != lines)
                report_mismatch("beat count", beat_count - beats_before, lines);
            for (i = 0; i < lines && sent_lines.size() > 0; i++)
            begin
                if (!mem_model.exists(base + byte_addr_t'(i * LINE_BYTES)))
                    report_failure("a line never reached memory");
                else if (mem_model[base + byte_addr_t'(i * LINE_BYTES)] !== sent_lines[0])
                    report_mismatch("m_axi_wdata", mem_model[base + byte_addr_t'(i * LINE_BYTES)],
                                    sent_lines[0]);
                void'(sent_lines.pop_front());
            end
        end
    endtask

    task automatic reset_state_check;
        @(posedge clk);
        if (idle !== 1'b1)
            report_mismatch("idle", idle, 1);
        if ({active, done, ack, m_axi_awvalid, m_axi_wvalid, m_axi_bready} !== 6'b0)
            report_mismatch("active/done/ack/awvalid/wvalid/bready",
                            {active, done, ack, m_axi_awvalid, m_axi_wvalid, m_axi_bready}, 0);
    endtask

    task automatic single_burst_transfer;
        feed_lines(5);
        run_transfer(29'h100, 5, 1'b0); // one burst, AWLEN 4.
    endtask

    // 8 lines short of a 4 KB page, so 8 + 16 + 16.
    task automatic page_split_transfer;
        fork
            feed_lines(40);
            run_transfer(29'h3F8, 40, 1'b0);
        join
    endtask

    task automatic stalled_write_transfer;
        heavy_stall = 1'b1;
        af_seen = 1'b0;
        fork
            feed_lines(64);
            run_transfer(29'h800, 64, 1'b0);
        join
        heavy_stall = 1'b0;
        if (!af_seen)
            report_failure("almost-full never rose while writes were stalled");
    endtask

    task automatic slave_error_transfer;
        err_addr = 32'h0001_0080; // second of two bursts.
        feed_lines(20);
        run_transfer(29'h2000, 20, 1'b1);
        err_addr = '1;
    endtask

    // lines queued before an empty transfer stay for the next one.
    task automatic empty_transfer;
        feed_lines(3);
        run_transfer(29'h3000, 0, 1'b0);
        run_transfer(29'h3000, 3, 1'b0);
    endtask

    initial
    begin
        void'($urandom(40));
        reset <= 1'b1;
        line_we <= 1'b0;
        line_wdata <= '0;
        start <= 1'b0;
        start_line_addr <= '0;
        start_length <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_state_check();
        single_burst_transfer();
        page_split_transfer();
        stalled_write_transfer();
        slave_error_transfer();
        empty_transfer();
        repeat (2) @(posedge clk);
        $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
                 error_count, timeout_count, UUT.checks.failures);
        if (error_count == 0 && timeout_count == 0 && UUT.checks.failures == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
